/* all.f */
common/ijtagPkg.sv
design/scanHeader.sv
wrappedSegment/wrappedSegment.sv
design/scanTail.sv
design/ijtagNetwork.sv
test/scanChecker.sv
test/networkTb.sv

/* common/ijtagPkg.sv */
// Shared scan-control and instrument word types for the iJTAG network; referenced by scoped name

package ijtagPkg;

    // ------------------------------------------------------------------------
    // Default sizes, the top level passes its own values down
    // ------------------------------------------------------------------------

    // Shadow and instrument register width, tied to instrWord_u below
    localparam int InstrWidth = 8;

    // Default number of wrapped segments behind the header SIB
    localparam int DefaultSegments = 4;

    // Default length of the SCB-inserted configuration register
    localparam int DefaultConfWidth = 16;

    // ------------------------------------------------------------------------
    // Scan control bundle
    // ------------------------------------------------------------------------

    // Plain iJTAG levels, sampled on the rising edge of TCK
    typedef struct packed {
        logic ce;
        logic se;
        logic ue;
        logic sel;
    } scanCtl_t;

    // ------------------------------------------------------------------------
    // Instrument word
    // ------------------------------------------------------------------------

    // Instrument view of the word
    // MSB arms the write, the rest is data
    typedef struct packed {
        logic                    wrEn;
        logic [InstrWidth-2:0]   payload;
    } instrFields_t;

    // Raw view is what gets shifted and captured,
    // the field view is what the instrument decodes
    typedef union packed {
        logic [InstrWidth-1:0] raw;
        instrFields_t          fields;
    } instrWord_u;

    // Reset value of any instrument word
    localparam instrWord_u InstrWordZero = '{raw: '0};

    // Handy widths for the top level and the tail
    localparam int ScanCtlWidth = $bits(scanCtl_t);

    // Word width and union width agree
    localparam int InstrWordBits = $bits(instrWord_u);

endpackage

/* design/ijtagNetwork.sv */
// Top level of the iJTAG scan network; header SIB, generated segment chain and SCB tail
`timescale 1ns/1ps

module ijtagNetwork #(
    parameter int NumSegments = ijtagPkg::DefaultSegments,
    parameter int ConfWidth   = ijtagPkg::DefaultConfWidth
) (
    input  logic TCK,
    input  logic RST,
    input  logic SI,
    input  logic CE,
    input  logic SE,
    input  logic UE,
    input  logic SEL,
    output logic SO
);

    ijtagPkg::scanCtl_t hostCtl;
    ijtagPkg::scanCtl_t segCtl;

    logic headerSo;
    logic headerOpen;

    // Scan links along the chain, entry 0 comes from the header
    logic [NumSegments:0] segLink;

    assign hostCtl = '{ce: CE, se: SE, ue: UE, sel: SEL};

    // ------------------------------------------------------------------------
    // Header SIB
    // ------------------------------------------------------------------------

    scanHeader i_header (
        .TCK        (TCK),
        .RST        (RST),
        .SI         (SI),
        .hostCtl    (hostCtl),
        .segCtl     (segCtl),
        .segSi      (segLink[0]),
        .headerSo   (headerSo),
        .headerOpen (headerOpen)
    );

    // ------------------------------------------------------------------------
    // Segment chain
    // ------------------------------------------------------------------------

    for (genvar k = 0; k < NumSegments; k++) begin : g_seg
        wrappedSegment i_seg (
            .TCK     (TCK),
            .RST     (RST),
            .segCtl  (segCtl),
            .scanIn  (segLink[k]),
            .scanOut (segLink[k+1])
        );
    end

    // Tail with SCB and configuration register
    scanTail #(
        .ConfWidth (ConfWidth)
    ) i_tail (
        .TCK        (TCK),
        .RST        (RST),
        .hostCtl    (hostCtl),
        .headerSo   (headerSo),
        .chainSo    (segLink[NumSegments]),
        .headerOpen (headerOpen),
        .SO         (SO)
    );

endmodule

/* design/scanHeader.sv */
// Header SIB of the network; gates the segment chain select and feeds its scan input
`timescale 1ns/1ps

module scanHeader (
    input  logic               TCK,
    input  logic               RST,
    input  logic               SI,
    input  ijtagPkg::scanCtl_t hostCtl,
    output ijtagPkg::scanCtl_t segCtl,
    output logic               segSi,
    output logic               headerSo,
    output logic               headerOpen
);

    logic sibShift;
    logic sibUpdate;
    logic capEn;
    logic shiftEn;
    logic updEn;

    assign capEn   = hostCtl.ce & hostCtl.sel;
    assign shiftEn = hostCtl.se & hostCtl.sel;
    assign updEn   = hostCtl.ue & hostCtl.sel;

    // ------------------------------------------------------------------------
    // SIB bit
    // ------------------------------------------------------------------------

    // Capture reads back the current open/closed state
    always_ff @(posedge TCK) begin
        if (capEn) begin
            sibShift <= sibUpdate;
        end else if (shiftEn) begin
            sibShift <= SI;
        end
    end

    always_ff @(posedge TCK) begin
        if (RST) begin
            sibUpdate <= 1'b0;
        end else if (updEn) begin
            sibUpdate <= sibShift;
        end
    end

    // Post-mux SIB with the chain hung behind the shift cell
    always_comb begin
        segCtl     = hostCtl;
        segCtl.sel = hostCtl.sel & sibUpdate;
    end

    assign segSi      = sibShift;
    assign headerSo   = sibShift;
    assign headerOpen = sibUpdate;

    // Segments only ever see select inside a host access
    assert property (@(posedge TCK) disable iff (RST) segCtl.sel |-> hostCtl.sel);

endmodule

/* design/scanTail.sv */
// Tail of the network; joins header and chain paths, holds the SCB and the configuration register
`timescale 1ns/1ps

module scanTail #(
    parameter int ConfWidth = ijtagPkg::DefaultConfWidth
) (
    input  logic               TCK,
    input  logic               RST,
    input  ijtagPkg::scanCtl_t hostCtl,
    input  logic               headerSo,
    input  logic               chainSo,
    input  logic               headerOpen,
    output logic               SO
);

    logic pathSrc;
    logic scbIn;
    logic scbShift;
    logic scbUpdate;
    logic confSel;

    logic [ConfWidth-1:0] confShift;
    logic [ConfWidth-1:0] confUpdate;

    // ------------------------------------------------------------------------
    // Path selection
    // ------------------------------------------------------------------------

    // Open header routes through the segment chain
    assign pathSrc = headerOpen ? chainSo : headerSo;

    // SCB set inserts the configuration register ahead of itself
    assign scbIn   = scbUpdate ? confShift[0] : pathSrc;
    assign confSel = hostCtl.sel & scbUpdate;

    // ------------------------------------------------------------------------
    // SCB
    // ------------------------------------------------------------------------

    always_ff @(posedge TCK) begin
        if (hostCtl.ce && hostCtl.sel) begin
            scbShift <= scbUpdate;
        end else if (hostCtl.se && hostCtl.sel) begin
            scbShift <= scbIn;
        end
    end

    always_ff @(posedge TCK) begin
        if (RST) begin
            scbUpdate <= 1'b0;
        end else if (hostCtl.ue && hostCtl.sel) begin
            scbUpdate <= scbShift;
        end
    end

    // ------------------------------------------------------------------------
    // Configuration register
    // ------------------------------------------------------------------------

    always_ff @(posedge TCK) begin
        if (hostCtl.ce && confSel) begin
            confShift <= confUpdate;
        end else if (hostCtl.se && confSel) begin
            confShift <= {pathSrc, confShift[ConfWidth-1:1]};
        end
    end

    always_ff @(posedge TCK) begin
        if (RST) begin
            confUpdate <= '0;
        end else if (hostCtl.ue && confSel) begin
            confUpdate <= confShift;
        end
    end

    assign SO = scbShift;

    // Configuration is frozen while it sits off the path
    assert property (@(posedge TCK) disable iff (RST)
        !$past(scbUpdate) |-> $stable(confUpdate));

endmodule

/* run.sh */
#!/bin/sh
# Builds the network testbench with Verilator, runs it and looks for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module networkTb -f all.f -o networkSim || exit 1
./obj_dir/networkSim | tee /dev/stderr | grep -x "test passed" > /dev/null && exit 0 || exit 1

/* test/networkTb.sv */
// Testbench top; reads scan transactions from the data file, drives the network, reports the result
`timescale 1ns/1ps

module networkTb;

    localparam int NumSegments = 4;
    localparam int ConfWidth   = 16;
    localparam int MaxLen      = 64;
    localparam int MaxTests    = 32;
    localparam int DoneTimeout = 8;

    logic TCK;
    logic RST;
    logic SI;
    logic CE;
    logic SE;
    logic UE;
    logic SEL;
    logic SO;

    // Four words per scan for number, shift length, SI word and expected SO word
    logic [MaxLen-1:0] testMem [0:4*MaxTests-1];
    logic [MaxLen-1:0] lenWord;

    int                testNum;
    logic [MaxLen-1:0] expWord;
    int                matchCount;
    int                mismatchCount;
    int                doneCount;
    int                testsRun;
    int                entry;
    int                entryLen;
    bit                endOfData;
    bit                timedOut;
    bit                badData;

    ijtagNetwork #(
        .NumSegments (NumSegments),
        .ConfWidth   (ConfWidth)
    ) i_dut (
        .TCK (TCK),
        .RST (RST),
        .SI  (SI),
        .CE  (CE),
        .SE  (SE),
        .UE  (UE),
        .SEL (SEL),
        .SO  (SO)
    );

    scanChecker #(
        .MaxLen (MaxLen)
    ) i_checker (
        .TCK           (TCK),
        .RST           (RST),
        .CE            (CE),
        .SE            (SE),
        .UE            (UE),
        .SEL           (SEL),
        .SO            (SO),
        .testNum       (testNum),
        .expWord       (expWord),
        .matchCount    (matchCount),
        .mismatchCount (mismatchCount),
        .doneCount     (doneCount)
    );

    always #4 TCK = ~TCK;

    // ------------------------------------------------------------------------
    // One scan of capture, shifts and update, then idle until the checker closes it
    // ------------------------------------------------------------------------

    task automatic runScan(input int num, input int len,
                           input logic [MaxLen-1:0] siWord, input logic [MaxLen-1:0] expected);
        int                i;
        int                waited;
        logic [MaxLen-1:0] siBits;
        @(negedge TCK);
        testNum  = num;
        expWord  = expected;
        CE       = 1'b1;
        SEL      = 1'b1;
        // SI word goes in LSB first
        for (i = 0; i < len; i++) begin
            @(negedge TCK);
            siBits = siWord >> i;
            CE     = 1'b0;
            SE     = 1'b1;
            SI     = siBits[0];
        end
        @(negedge TCK);
        SE = 1'b0;
        SI = 1'b0;
        UE = 1'b1;
        @(negedge TCK);
        UE       = 1'b0;
        SEL      = 1'b0;
        testsRun = testsRun + 1;
        waited   = 0;
        while (doneCount < testsRun && waited < DoneTimeout) begin
            @(negedge TCK);
            waited = waited + 1;
        end
        if (doneCount < testsRun) begin
            $display("Timeout: the checker never closed scan %0d", num);
            timedOut = 1'b1;
        end
    endtask

    initial begin
        TCK       = 1'b0;
        RST       = 1'b1;
        SI        = 1'b0;
        CE        = 1'b0;
        SE        = 1'b0;
        UE        = 1'b0;
        SEL       = 1'b0;
        testNum   = 0;
        expWord   = '0;
        testsRun  = 0;
        entry     = 0;
        endOfData = 1'b0;
        timedOut  = 1'b0;
        badData   = 1'b0;
        $readmemh("test/networkTestdata.txt", testMem);
        repeat (16) @(posedge TCK);
        @(negedge TCK);
        RST = 1'b0;

        // A zero shift length marks the end of the data
        while (!endOfData && !timedOut && entry < MaxTests) begin
            lenWord  = testMem[4*entry+1];
            entryLen = lenWord[31:0];
            if (entryLen == 0) begin
                endOfData = 1'b1;
            end else if (entryLen > MaxLen) begin
                $display("Data file entry %0d asks for more than %0d shift bits", entry, MaxLen);
                badData   = 1'b1;
                endOfData = 1'b1;
            end else begin
                lenWord = testMem[4*entry];
                runScan(lenWord[31:0], entryLen, testMem[4*entry+2], testMem[4*entry+3]);
            end
            entry = entry + 1;
        end

        $display("Summary: %0d scans run, %0d matched, %0d mismatched",
                 testsRun, matchCount, mismatchCount);
        if (!timedOut && !badData && testsRun > 0 && mismatchCount == 0
            && doneCount == testsRun) begin
            $display("test passed");
        end else begin
            if (testsRun == 0) begin
                $display("No scans were read from the data file");
            end
            $display("test failed");
        end
        $finish;
    end

endmodule

/* test/networkTestdata.txt */
// Columns, all hex: scan number, shift length, SI word, expected SO word
// SI and SO words are LSB first, a zero length ends the list
// Reset path is header SIB and SCB only
01 02 00000000 00000000
// Open the header SIB
02 02 00000002 00000000
// Header plus four closed segment SIBs, header bit reads back as 1
03 06 00000020 00000020
// Open segment 0
04 06 00000030 00000020
// Segment 0 shadow inserted, write a5 with write enable set
05 0e 000034b0 00002010
// Instrument reads a5, write 3c with write enable clear
06 0e 00002790 000034b0
07 0e 00002790 000034b0
// Set the SCB
08 0e 00002791 000034b0
// Configuration register in front of the SCB, write beef
09 1e 27917ddf 34b00001
// Read beef back and clear the SCB
0a 1e 27917dde 34b17ddf
// Short path again
0b 0e 00002790 000034b0
// Close segment 0 and the header
0c 0e 00000000 000034b0
0d 02 00000000 00000000
00 00 00000000 00000000

/* test/scanChecker.sv */
// Scan response checker; watches SO on every shift cycle and compares it with the expected word
`timescale 1ns/1ps

module scanChecker #(
    parameter int MaxLen = 64
) (
    input  logic              TCK,
    input  logic              RST,
    input  logic              CE,
    input  logic              SE,
    input  logic              UE,
    input  logic              SEL,
    input  logic              SO,
    input  int                testNum,
    input  logic [MaxLen-1:0] expWord,
    output int                matchCount,
    output int                mismatchCount,
    output int                doneCount
);

    int                bitIdx;
    int                bitErrors;
    logic [MaxLen-1:0] gotWord;
    logic [MaxLen-1:0] expShifted;

    // ------------------------------------------------------------------------
    // Sampling on the rising edge while SO still holds the bit of this cycle
    // ------------------------------------------------------------------------

    always @(posedge TCK) begin
        if (RST) begin
            bitIdx        = 0;
            bitErrors     = 0;
            gotWord       = '0;
            matchCount    = 0;
            mismatchCount = 0;
            doneCount     = 0;
        end else if (SEL && CE) begin
            // SO now shows the captured last cell of a new scan
            bitIdx    = 0;
            bitErrors = 0;
            gotWord   = '0;
        end else if (SEL && SE) begin
            expShifted = expWord >> bitIdx;
            gotWord    = gotWord | ({{(MaxLen-1){1'b0}}, SO} << bitIdx);
            if (SO !== expShifted[0]) begin
                $display("Error at %0d ns: scan %0d, SO bit %0d expected %b, got %b",
                         $time, testNum, bitIdx, expShifted[0], SO);
                bitErrors = bitErrors + 1;
            end
            bitIdx = bitIdx + 1;
        end else if (SEL && UE) begin
            // Update edge closes the scan
            if (bitErrors == 0) begin
                matchCount = matchCount + 1;
                $display("Scan %0d: match, %0d bits, SO word %h", testNum, bitIdx, gotWord);
            end else begin
                mismatchCount = mismatchCount + 1;
                $display("Scan %0d: mismatch, SO word %h, expected %h",
                         testNum, gotWord, expWord);
            end
            doneCount = doneCount + 1;
        end
    end

endmodule

/* wrappedSegment/wrappedSegment.sv */
// One SIB-gated segment with an 8-bit shadow scan register and its instrument register
`timescale 1ns/1ps

module wrappedSegment (
    input  logic               TCK,
    input  logic               RST,
    input  ijtagPkg::scanCtl_t segCtl,
    input  logic               scanIn,
    output logic               scanOut
);

    localparam int Width = ijtagPkg::InstrWidth;

    // SIB state
    logic sibShift;
    logic sibUpdate;
    logic sibIn;

    // Shadow register, raw view while shifting, decoded view after update
    ijtagPkg::instrWord_u shadowShift;
    ijtagPkg::instrWord_u shadowUpdate;

    // Instrument data register
    logic [Width-1:0] instrReg;

    // Qualified controls for the two scan registers
    logic sibCap;
    logic sibShiftEn;
    logic sibUpd;
    logic shadowSel;
    logic shadowCap;
    logic shadowShiftEn;
    logic shadowUpd;

    // ------------------------------------------------------------------------
    // Control qualification
    // ------------------------------------------------------------------------

    assign sibCap     = segCtl.ce & segCtl.sel;
    assign sibShiftEn = segCtl.se & segCtl.sel;
    assign sibUpd     = segCtl.ue & segCtl.sel;

    // Shadow register only lives on the path while the SIB is open
    assign shadowSel     = segCtl.sel & sibUpdate;
    assign shadowCap     = segCtl.ce & shadowSel;
    assign shadowShiftEn = segCtl.se & shadowSel;
    assign shadowUpd     = segCtl.ue & shadowSel;

    // ------------------------------------------------------------------------
    // SIB bit
    // ------------------------------------------------------------------------

    // Open SIB puts the shadow register in front of the SIB bit
    assign sibIn = sibUpdate ? shadowShift.raw[0] : scanIn;

    always_ff @(posedge TCK) begin
        if (sibCap) begin
            sibShift <= sibUpdate;
        end else if (sibShiftEn) begin
            sibShift <= sibIn;
        end
    end

    always_ff @(posedge TCK) begin
        if (RST) begin
            sibUpdate <= 1'b0;
        end else if (sibUpd) begin
            sibUpdate <= sibShift;
        end
    end

    // SIB bit is always the last cell of the segment
    assign scanOut = sibShift;

    // ------------------------------------------------------------------------
    // Shadow scan register
    // ------------------------------------------------------------------------

    // New bits enter at the top cell, cell 0 drives the SIB
    always_ff @(posedge TCK) begin
        if (shadowCap) begin
            shadowShift.raw <= instrReg;
        end else if (shadowShiftEn) begin
            shadowShift.raw <= {scanIn, shadowShift.raw[Width-1:1]};
        end
    end

    always_ff @(posedge TCK) begin
        if (RST) begin
            shadowUpdate <= ijtagPkg::InstrWordZero;
        end else if (shadowUpd) begin
            shadowUpdate <= shadowShift;
        end
    end

    // ------------------------------------------------------------------------
    // Instrument
    // ------------------------------------------------------------------------

    // Loads the whole word, write enable included, for as long as
    // the update register keeps the enable set
    always_ff @(posedge TCK) begin
        if (RST) begin
            instrReg <= '0;
        end else if (shadowUpdate.fields.wrEn) begin
            instrReg <= shadowUpdate.raw;
        end
    end

    // Instrument data moves only after an armed update word
    assert property (@(posedge TCK) disable iff (RST)
        !$stable(instrReg) |-> $past(shadowUpdate.fields.wrEn));

endmodule
